// ==== verilog/xaui_reg_pkg.sv ====
package xaui_reg_pkg;

  // register indices, taken from wb_adr_i[5:1]
  localparam logic [4:0] REG_TXDATA3    = 5'd0;
  localparam logic [4:0] REG_TXDATA2    = 5'd1;
  localparam logic [4:0] REG_TXDATA1    = 5'd2;
  localparam logic [4:0] REG_TXDATA0    = 5'd3;
  localparam logic [4:0] REG_TXADVANCE  = 5'd4;
  localparam logic [4:0] REG_TXSTATUS   = 5'd5;
  localparam logic [4:0] REG_RXDATA3    = 5'd6;
  localparam logic [4:0] REG_RXDATA2    = 5'd7;
  localparam logic [4:0] REG_RXDATA1    = 5'd8;
  localparam logic [4:0] REG_RXDATA0    = 5'd9;
  localparam logic [4:0] REG_RXADVANCE  = 5'd10;
  localparam logic [4:0] REG_RXSTATUS   = 5'd11;
  localparam logic [4:0] REG_LINKSTATUS = 5'd12;
  localparam logic [4:0] REG_POWERDOWN  = 5'd13;
  localparam logic [4:0] REG_LOOPBACK   = 5'd14;
  localparam logic [4:0] REG_TXEN       = 5'd15;
  localparam logic [4:0] REG_RESET      = 5'd16;
  localparam logic [4:0] REG_RXPHYCONF  = 5'd17;
  localparam logic [4:0] REG_TXPHYCONF  = 5'd18;
  localparam logic [4:0] REG_ERRCNT3    = 5'd19;
  localparam logic [4:0] REG_ERRCNT2    = 5'd20;
  localparam logic [4:0] REG_ERRCNT1    = 5'd21;
  localparam logic [4:0] REG_ERRCNT0    = 5'd22;
  localparam logic [4:0] REG_DATACNT3   = 5'd23;
  localparam logic [4:0] REG_DATACNT2   = 5'd24;
  localparam logic [4:0] REG_DATACNT1   = 5'd25;
  localparam logic [4:0] REG_DATACNT0   = 5'd26;

  // control bit values after reset
  localparam bit DEF_POWERDOWN = 1'b0;
  localparam bit DEF_LOOPBACK  = 1'b0;
  localparam bit DEF_TXEN      = 1'b1;

  typedef struct packed {
    logic [3:0] pad_hi;
    logic [3:0] eq_pole;  // bits 11:8
    logic [5:0] pad_lo;
    logic [1:0] eq_mix;   // bits 1:0
  } phy_rx_view_t;

  typedef struct packed {
    logic [4:0] pad_hi;
    logic [2:0] diff_ctrl;    // bits 10:8
    logic [4:0] pad_lo;
    logic [2:0] preemphasis;  // bits 2:0
  } phy_tx_view_t;

  // one halfword, read as receive or transmit settings depending on the register
  typedef union packed {
    phy_rx_view_t rx;
    phy_tx_view_t tx;
  } phy_conf_word_t;

endpackage

// ==== verilog/xaui_fifo_pkg.sv ====
package xaui_fifo_pkg;

  // width of one transmit or receive word
  localparam int WORD_W = 64;

  // status word layout
  localparam int STAT_W           = 4;
  localparam int STAT_EMPTY       = 0;
  localparam int STAT_FULL        = 1;
  localparam int STAT_ALMOST_FULL = 2;  // one free slot or less
  localparam int STAT_OVERFLOW    = 3;  // sticky until reset or clear

endpackage

// ==== verilog/xaui_sync_fifo.sv ====
module xaui_sync_fifo #(
  parameter int FIFO_AW = 2
) (
  input  logic                              wb_clk_i,
  input  logic                              reset,
  input  logic                              clear_i,
  input  logic                              push_i,
  input  logic [xaui_fifo_pkg::WORD_W-1:0]  data_i,
  input  logic                              pop_i,
  output logic [xaui_fifo_pkg::WORD_W-1:0]  data_o,
  output logic [xaui_fifo_pkg::STAT_W-1:0]  status_o
);

  localparam logic [FIFO_AW:0] DEPTH = (FIFO_AW+1)'(2**FIFO_AW);

  logic [xaui_fifo_pkg::WORD_W-1:0] mem [2**FIFO_AW];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               overflow;
  logic               empty;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign empty = (count == '0);
  assign full  = (count == DEPTH);

  // a push into a full fifo is lost, a pop of an empty one does nothing
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty;

  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push & ~do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop & ~do_push) begin
        count <= count - 1'b1;
      end

      if (clear_i) begin
        overflow <= 1'b0;
      end else if (push_i & full) begin
        overflow <= 1'b1;
      end
    end
  end

  assign data_o = mem[rd_ptr];  // head word falls through

  always_comb begin
    status_o = '0;
    status_o[xaui_fifo_pkg::STAT_EMPTY]       = empty;
    status_o[xaui_fifo_pkg::STAT_FULL]        = full;
    status_o[xaui_fifo_pkg::STAT_ALMOST_FULL] = (count >= DEPTH - 1'b1);
    status_o[xaui_fifo_pkg::STAT_OVERFLOW]    = overflow;
  end

endmodule

// ==== verilog/xaui_link_counters.sv ====
module xaui_link_counters (
  input  logic        wb_clk_i,
  input  logic        reset,
  input  logic        clear_i,
  input  logic        word_i,
  input  logic        err_i,
  output logic [63:0] data_count_o,
  output logic [63:0] error_count_o
);

  // slot 0 counts received words, slot 1 counts errors
  logic [63:0] count [2];
  logic [1:0]  event_pulse;

  assign event_pulse = {err_i, word_i};

  always_ff @(posedge wb_clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (reset | clear_i) begin
        count[i] <= '0;
      end else if (event_pulse[i]) begin
        count[i] <= count[i] + 64'd1;  // wraps at 2^64
      end
    end
  end

  assign data_count_o  = count[0];
  assign error_count_o = count[1];

endmodule

// ==== verilog/xaui_wb_attach.sv ====
module xaui_wb_attach #(
  parameter bit DEFAULT_POWERDOWN = 1'b0,
  parameter bit DEFAULT_LOOPBACK  = 1'b0,
  parameter bit DEFAULT_TXEN      = 1'b1
) (
  input  logic        wb_clk_i,
  input  logic        reset,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,

  output logic        user_loopback_o,
  output logic        user_powerdown_o,
  output logic        user_txen_o,
  output logic        user_xaui_reset_strb_o,

  output logic [1:0]  mgt_rxeqmix_o,
  output logic [3:0]  mgt_rxeqpole_o,
  output logic [2:0]  mgt_txpreemphasis_o,
  output logic [2:0]  mgt_txdiffctrl_o,

  output logic                             tx_fifo_wr_en_o,
  output logic [xaui_fifo_pkg::WORD_W-1:0] tx_fifo_data_o,
  input  logic [xaui_fifo_pkg::STAT_W-1:0] tx_fifo_status_i,

  output logic                             rx_fifo_rd_en_o,
  input  logic [xaui_fifo_pkg::WORD_W-1:0] rx_fifo_data_i,
  input  logic [xaui_fifo_pkg::STAT_W-1:0] rx_fifo_status_i,

  input  logic [7:0]  xaui_status_i,
  input  logic [63:0] error_count_i,
  input  logic [63:0] data_count_i
);

  logic [4:0] reg_idx;
  logic [4:0] wb_dat_o_src;   // index latched at the request, used during ack
  logic       req;
  logic [1:0] tx_hw;          // halfword of the staging word, 0 is least significant

  xaui_reg_pkg::phy_conf_word_t phy_wr;
  xaui_reg_pkg::phy_conf_word_t rx_conf_rd;
  xaui_reg_pkg::phy_conf_word_t tx_conf_rd;

  assign reg_idx = wb_adr_i[5:1];
  assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign tx_hw   = 2'd3 - reg_idx[1:0];
  assign phy_wr  = wb_dat_i;

  always_ff @(posedge wb_clk_i) begin
    // strobes last a single cycle
    wb_ack_o               <= 1'b0;
    user_xaui_reset_strb_o <= 1'b0;
    tx_fifo_wr_en_o        <= 1'b0;
    rx_fifo_rd_en_o        <= 1'b0;

    if (reset) begin
      user_powerdown_o    <= DEFAULT_POWERDOWN;
      user_loopback_o     <= DEFAULT_LOOPBACK;
      user_txen_o         <= DEFAULT_TXEN;
      mgt_rxeqmix_o       <= '0;
      mgt_rxeqpole_o      <= '0;
      mgt_txpreemphasis_o <= '0;
      mgt_txdiffctrl_o    <= '0;
      tx_fifo_data_o      <= '0;
      wb_dat_o_src        <= '0;
    end else if (req) begin
      wb_ack_o     <= 1'b1;
      wb_dat_o_src <= reg_idx;

      if (wb_we_i) begin
        case (reg_idx)
          xaui_reg_pkg::REG_TXDATA3, xaui_reg_pkg::REG_TXDATA2,
          xaui_reg_pkg::REG_TXDATA1, xaui_reg_pkg::REG_TXDATA0: begin
            // each byte lane is staged separately
            if (wb_sel_i[1]) begin
              tx_fifo_data_o[{tx_hw, 4'd8} +: 8] <= wb_dat_i[15:8];
            end
            if (wb_sel_i[0]) begin
              tx_fifo_data_o[{tx_hw, 4'd0} +: 8] <= wb_dat_i[7:0];
            end
          end
          xaui_reg_pkg::REG_TXADVANCE: begin
            if (wb_sel_i[0] & wb_dat_i[0]) tx_fifo_wr_en_o <= 1'b1;
          end
          xaui_reg_pkg::REG_RXADVANCE: begin
            if (wb_sel_i[0] & wb_dat_i[0]) rx_fifo_rd_en_o <= 1'b1;
          end
          xaui_reg_pkg::REG_POWERDOWN: begin
            if (wb_sel_i[0]) user_powerdown_o <= wb_dat_i[0];
          end
          xaui_reg_pkg::REG_LOOPBACK: begin
            if (wb_sel_i[0]) user_loopback_o <= wb_dat_i[0];
          end
          xaui_reg_pkg::REG_TXEN: begin
            if (wb_sel_i[0]) user_txen_o <= wb_dat_i[0];
          end
          xaui_reg_pkg::REG_RESET: begin
            if (wb_sel_i[0] & wb_dat_i[0]) user_xaui_reset_strb_o <= 1'b1;
          end
          xaui_reg_pkg::REG_RXPHYCONF: begin
            if (wb_sel_i[0]) mgt_rxeqmix_o <= phy_wr.rx.eq_mix;
            if (wb_sel_i[1]) mgt_rxeqpole_o <= phy_wr.rx.eq_pole;
          end
          xaui_reg_pkg::REG_TXPHYCONF: begin
            if (wb_sel_i[0]) mgt_txpreemphasis_o <= phy_wr.tx.preemphasis;
            if (wb_sel_i[1]) mgt_txdiffctrl_o <= phy_wr.tx.diff_ctrl;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // phy settings packed back into their halfword layout for reads
  always_comb begin
    rx_conf_rd.rx = '{pad_hi: 4'h0, eq_pole: mgt_rxeqpole_o, pad_lo: 6'h0,
                      eq_mix: mgt_rxeqmix_o};
  end

  always_comb begin
    tx_conf_rd.tx = '{pad_hi: 5'h0, diff_ctrl: mgt_txdiffctrl_o, pad_lo: 5'h0,
                      preemphasis: mgt_txpreemphasis_o};
  end

  always_comb begin
    case (wb_dat_o_src)
      xaui_reg_pkg::REG_TXDATA3:    wb_dat_o = tx_fifo_data_o[63:48];
      xaui_reg_pkg::REG_TXDATA2:    wb_dat_o = tx_fifo_data_o[47:32];
      xaui_reg_pkg::REG_TXDATA1:    wb_dat_o = tx_fifo_data_o[31:16];
      xaui_reg_pkg::REG_TXDATA0:    wb_dat_o = tx_fifo_data_o[15:0];
      xaui_reg_pkg::REG_TXSTATUS:   wb_dat_o = 16'(tx_fifo_status_i);
      xaui_reg_pkg::REG_RXDATA3:    wb_dat_o = rx_fifo_data_i[63:48];
      xaui_reg_pkg::REG_RXDATA2:    wb_dat_o = rx_fifo_data_i[47:32];
      xaui_reg_pkg::REG_RXDATA1:    wb_dat_o = rx_fifo_data_i[31:16];
      xaui_reg_pkg::REG_RXDATA0:    wb_dat_o = rx_fifo_data_i[15:0];
      xaui_reg_pkg::REG_RXSTATUS:   wb_dat_o = 16'(rx_fifo_status_i);
      xaui_reg_pkg::REG_LINKSTATUS: wb_dat_o = 16'(xaui_status_i);
      xaui_reg_pkg::REG_POWERDOWN:  wb_dat_o = 16'(user_powerdown_o);
      xaui_reg_pkg::REG_LOOPBACK:   wb_dat_o = 16'(user_loopback_o);
      xaui_reg_pkg::REG_TXEN:       wb_dat_o = 16'(user_txen_o);
      xaui_reg_pkg::REG_RXPHYCONF:  wb_dat_o = rx_conf_rd;
      xaui_reg_pkg::REG_TXPHYCONF:  wb_dat_o = tx_conf_rd;
      xaui_reg_pkg::REG_ERRCNT3:    wb_dat_o = error_count_i[63:48];
      xaui_reg_pkg::REG_ERRCNT2:    wb_dat_o = error_count_i[47:32];
      xaui_reg_pkg::REG_ERRCNT1:    wb_dat_o = error_count_i[31:16];
      xaui_reg_pkg::REG_ERRCNT0:    wb_dat_o = error_count_i[15:0];
      xaui_reg_pkg::REG_DATACNT3:   wb_dat_o = data_count_i[63:48];
      xaui_reg_pkg::REG_DATACNT2:   wb_dat_o = data_count_i[47:32];
      xaui_reg_pkg::REG_DATACNT1:   wb_dat_o = data_count_i[31:16];
      xaui_reg_pkg::REG_DATACNT0:   wb_dat_o = data_count_i[15:0];
      default:                      wb_dat_o = 16'h0000;  // strobes and unmapped
    endcase
  end

endmodule

// ==== verilog/xaui_wb_subsys.sv ====
module xaui_wb_subsys #(
  parameter bit DEFAULT_POWERDOWN = xaui_reg_pkg::DEF_POWERDOWN,
  parameter bit DEFAULT_LOOPBACK  = xaui_reg_pkg::DEF_LOOPBACK,
  parameter bit DEFAULT_TXEN      = xaui_reg_pkg::DEF_TXEN,
  parameter int FIFO_AW           = 2
) (
  input  logic        wb_clk_i,
  input  logic        reset,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,

  output logic        user_loopback_o,
  output logic        user_powerdown_o,
  output logic        user_txen_o,
  output logic        user_xaui_reset_strb_o,
  output logic [1:0]  mgt_rxeqmix_o,
  output logic [3:0]  mgt_rxeqpole_o,
  output logic [2:0]  mgt_txpreemphasis_o,
  output logic [2:0]  mgt_txdiffctrl_o,

  output logic [63:0] tx_word_o,
  output logic        tx_valid_o,
  input  logic        tx_pop_i,
  input  logic [63:0] rx_word_i,
  input  logic        rx_push_i,
  input  logic        rx_err_i,
  input  logic [7:0]  xaui_status_i
);

  logic                             tx_fifo_wr_en;
  logic [xaui_fifo_pkg::WORD_W-1:0] tx_fifo_data;
  logic [xaui_fifo_pkg::STAT_W-1:0] tx_fifo_status;
  logic                             tx_fifo_empty;
  logic                             rx_fifo_rd_en;
  logic [xaui_fifo_pkg::WORD_W-1:0] rx_fifo_data;
  logic [xaui_fifo_pkg::STAT_W-1:0] rx_fifo_status;
  logic [63:0]                      error_count;
  logic [63:0]                      data_count;

  assign tx_fifo_empty = tx_fifo_status[xaui_fifo_pkg::STAT_EMPTY];
  assign tx_valid_o    = ~tx_fifo_empty;

  xaui_wb_attach #(
    .DEFAULT_POWERDOWN (DEFAULT_POWERDOWN),
    .DEFAULT_LOOPBACK  (DEFAULT_LOOPBACK),
    .DEFAULT_TXEN      (DEFAULT_TXEN)
  ) attach (
    .wb_clk_i, .reset, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_sel_i,
    .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .user_loopback_o, .user_powerdown_o, .user_txen_o, .user_xaui_reset_strb_o,
    .mgt_rxeqmix_o, .mgt_rxeqpole_o, .mgt_txpreemphasis_o, .mgt_txdiffctrl_o,
    .tx_fifo_wr_en_o  (tx_fifo_wr_en),
    .tx_fifo_data_o   (tx_fifo_data),
    .tx_fifo_status_i (tx_fifo_status),
    .rx_fifo_rd_en_o  (rx_fifo_rd_en),
    .rx_fifo_data_i   (rx_fifo_data),
    .rx_fifo_status_i (rx_fifo_status),
    .xaui_status_i,
    .error_count_i    (error_count),
    .data_count_i     (data_count)
  );

  // host side pushes, link side pops
  xaui_sync_fifo #(.FIFO_AW(FIFO_AW)) tx_fifo (
    .wb_clk_i, .reset,
    .clear_i  (user_xaui_reset_strb_o),
    .push_i   (tx_fifo_wr_en),
    .data_i   (tx_fifo_data),
    .pop_i    (tx_pop_i),
    .data_o   (tx_word_o),
    .status_o (tx_fifo_status)
  );

  xaui_sync_fifo #(.FIFO_AW(FIFO_AW)) rx_fifo (
    .wb_clk_i, .reset,
    .clear_i  (user_xaui_reset_strb_o),
    .push_i   (rx_push_i),
    .data_i   (rx_word_i),
    .pop_i    (rx_fifo_rd_en),
    .data_o   (rx_fifo_data),
    .status_o (rx_fifo_status)
  );

  xaui_link_counters counters (
    .wb_clk_i, .reset,
    .clear_i       (user_xaui_reset_strb_o),
    .word_i        (rx_push_i),
    .err_i         (rx_err_i),
    .data_count_o  (data_count),
    .error_count_o (error_count)
  );

endmodule

// ==== sim/xaui_wb_checker.sv ====
module xaui_wb_checker (
  input logic wb_clk_i,
  input logic reset,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic reset_strb_i,
  input logic tx_push_i,
  input logic rx_pop_i,
  input logic tx_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;  // read by the testbench
  logic        req;

  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_i;

  ack_after_req: assert property (@(posedge wb_clk_i) disable iff (reset) req |=> wb_ack_i)
    else begin fail_count++; $error("no ack one cycle after a bus request"); end

  ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (reset) wb_ack_i |=> !wb_ack_i)
    else begin fail_count++; $error("ack stayed high for more than one cycle"); end

  ack_needs_req: assert property (@(posedge wb_clk_i) disable iff (reset)
    wb_ack_i |-> $past(req))
    else begin fail_count++; $error("ack without a request in the cycle before"); end

  // the xaui reset strobe is a single pulse
  strb_one_cycle: assert property (@(posedge wb_clk_i) disable iff (reset)
    reset_strb_i |=> !reset_strb_i)
    else begin fail_count++; $error("xaui reset strobe wider than one cycle"); end

  push_with_ack: assert property (@(posedge wb_clk_i) disable iff (reset)
    (tx_push_i | rx_pop_i) |-> wb_ack_i)
    else begin fail_count++; $error("fifo advance strobe outside the ack cycle"); end

  quiet_in_reset: assert property (@(posedge wb_clk_i)
    reset |=> !(wb_ack_i | reset_strb_i | tx_push_i | rx_pop_i | tx_valid_i))
    else begin fail_count++; $error("ack, strobe or valid high while in reset"); end

endmodule

// ==== sim/xaui_wb_tb.sv ====
module xaui_wb_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam bit P_POWERDOWN = 1'b0;
  localparam bit P_LOOPBACK  = 1'b0;
  localparam bit P_TXEN      = 1'b1;
  localparam int P_FIFO_AW   = 2;
  localparam int DEPTH       = 2**P_FIFO_AW;
  localparam int ACK_LIMIT   = 16;

  logic        wb_clk_i;
  logic        reset;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [1:0]  wb_sel_i;
  logic [31:0] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  logic        user_loopback_o;
  logic        user_powerdown_o;
  logic        user_txen_o;
  logic        user_xaui_reset_strb_o;
  logic [1:0]  mgt_rxeqmix_o;
  logic [3:0]  mgt_rxeqpole_o;
  logic [2:0]  mgt_txpreemphasis_o;
  logic [2:0]  mgt_txdiffctrl_o;
  logic [63:0] tx_word_o;
  logic        tx_valid_o;
  logic        tx_pop_i;
  logic [63:0] rx_word_i;
  logic        rx_push_i;
  logic        rx_err_i;
  logic [7:0]  xaui_status_i;

  logic [31:0] seed = 32'h3c95_9910;
  logic [63:0] tx_stage;  // what the staging register should hold
  logic [63:0] rx_model[$];
  logic        rx_ovf;
  logic [63:0] data_cnt;
  logic [63:0] err_cnt;

  xaui_wb_subsys #(
    .DEFAULT_POWERDOWN (P_POWERDOWN),
    .DEFAULT_LOOPBACK  (P_LOOPBACK),
    .DEFAULT_TXEN      (P_TXEN),
    .FIFO_AW           (P_FIFO_AW)
  ) dut (.*);

  bind xaui_wb_subsys xaui_wb_checker bus_chk (
    .wb_clk_i, .reset, .wb_cyc_i, .wb_stb_i,
    .wb_ack_i     (wb_ack_o),
    .reset_strb_i (user_xaui_reset_strb_o),
    .tx_push_i    (tx_fifo_wr_en),
    .rx_pop_i     (rx_fifo_rd_en),
    .tx_valid_i   (tx_valid_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  always @(negedge wb_clk_i) begin
    if (dut.bus_chk.fail_count != 0) begin
      $display("a bus or strobe timing assertion failed");
      $display("FAIL: see errors above");
      $fatal(1, "checker assertion failed");
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_word(output logic [63:0] w);
    seed = lcg_step(seed);
    w[63:32] = seed;
    seed = lcg_step(seed);
    w[31:0] = seed;
  endtask

  // status bits as the fifo rules define them for a given fill level
  function automatic logic [15:0] fifo_status(input int fill, input bit ovf);
    logic [15:0] s;
    s = '0;
    s[xaui_fifo_pkg::STAT_EMPTY]       = (fill == 0);
    s[xaui_fifo_pkg::STAT_FULL]        = (fill == DEPTH);
    s[xaui_fifo_pkg::STAT_ALMOST_FULL] = (fill >= DEPTH - 1);
    s[xaui_fifo_pkg::STAT_OVERFLOW]    = ovf;
    return s;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic bus_cycle(input logic we, input logic [4:0] idx, input logic [1:0] sel,
                           input logic [15:0] wdata, output logic [15:0] rdata);
    int waited;
    waited = 0;
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_adr_i = {26'h0, idx, 1'b0};
    wb_dat_i = wdata;
    @(negedge wb_clk_i);
    while (!wb_ack_o && waited < ACK_LIMIT) begin
      @(negedge wb_clk_i);
      waited++;
    end
    if (!wb_ack_o) begin
      $display("bus access to register %0d got no ack within %0d cycles", idx, ACK_LIMIT);
      $display("FAIL: see errors above");
      $fatal(1, "bus timeout");
    end
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] idx, input logic [1:0] sel, input logic [15:0] d);
    logic [15:0] unused_rd;
    bus_cycle(1'b1, idx, sel, d, unused_rd);
  endtask

  task automatic expect_reg(input logic [4:0] idx, input logic [15:0] exp);
    logic [15:0] rd;
    bus_cycle(1'b0, idx, 2'b11, 16'h0, rd);
    compare_value($sformatf("wb_dat_o at register %0d", idx), 64'(rd), 64'(exp));
  endtask

  task automatic push_rx(input logic [63:0] w);
    @(negedge wb_clk_i);
    rx_word_i = w;
    rx_push_i = 1'b1;
    @(negedge wb_clk_i);
    rx_push_i = 1'b0;
    data_cnt  = data_cnt + 64'd1;
    if (rx_model.size() < DEPTH) begin
      rx_model.push_back(w);
    end else begin
      rx_ovf = 1'b1;  // a full fifo drops the word
    end
  endtask

  task automatic pulse_err();
    @(negedge wb_clk_i);
    rx_err_i = 1'b1;
    @(negedge wb_clk_i);
    rx_err_i = 1'b0;
    err_cnt = err_cnt + 64'd1;
  endtask

  task automatic drain_rx_word();
    logic [63:0] exp;
    exp = rx_model.pop_front();
    for (int h = 0; h < 4; h++) begin
      expect_reg(xaui_reg_pkg::REG_RXDATA3 + 5'(h), 16'(exp >> (48 - 16*h)));
    end
    write_reg(xaui_reg_pkg::REG_RXADVANCE, 2'b01, 16'h0001);
  endtask

  task automatic verify_phy(input logic [1:0] mix, input logic [3:0] pole,
                            input logic [2:0] pre, input logic [2:0] diff);
    compare_value("mgt_rxeqmix_o", 64'(mgt_rxeqmix_o), 64'(mix));
    compare_value("mgt_rxeqpole_o", 64'(mgt_rxeqpole_o), 64'(pole));
    compare_value("mgt_txpreemphasis_o", 64'(mgt_txpreemphasis_o), 64'(pre));
    compare_value("mgt_txdiffctrl_o", 64'(mgt_txdiffctrl_o), 64'(diff));
    expect_reg(xaui_reg_pkg::REG_RXPHYCONF, {4'h0, pole, 6'h0, mix});
    expect_reg(xaui_reg_pkg::REG_TXPHYCONF, {5'h0, diff, 5'h0, pre});
  endtask

  initial begin
    logic [63:0] w;
    logic [1:0]  sel;
    logic [15:0] hw;
    reset = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_sel_i = 2'b00;
    wb_adr_i = '0;
    wb_dat_i = '0;
    tx_pop_i = 1'b0;
    rx_word_i = '0;
    rx_push_i = 1'b0;
    rx_err_i = 1'b0;
    xaui_status_i = '0;
    tx_stage = '0;
    rx_ovf = 1'b0;
    data_cnt = '0;
    err_cnt = '0;
    repeat (5) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    reset = 1'b0;

    expect_reg(xaui_reg_pkg::REG_POWERDOWN, 16'(P_POWERDOWN));
    expect_reg(xaui_reg_pkg::REG_LOOPBACK, 16'(P_LOOPBACK));
    expect_reg(xaui_reg_pkg::REG_TXEN, 16'(P_TXEN));
    verify_phy(2'h0, 4'h0, 3'h0, 3'h0);
    expect_reg(xaui_reg_pkg::REG_TXSTATUS, fifo_status(0, 1'b0));
    expect_reg(xaui_reg_pkg::REG_RXSTATUS, fifo_status(0, 1'b0));
    compare_value("tx_valid_o", 64'(tx_valid_o), 64'h0);

    // second halfword gets its upper byte only, its lower byte keeps the reset zero
    next_word(w);
    for (int i = 0; i < 4; i++) begin
      sel = (i == 1) ? 2'b10 : 2'b11;
      hw  = 16'(w >> (48 - 16*i));
      write_reg(xaui_reg_pkg::REG_TXDATA3 + 5'(i), sel, hw);
      if (sel[1]) tx_stage[63 - 16*i -: 8] = hw[15:8];
      if (sel[0]) tx_stage[55 - 16*i -: 8] = hw[7:0];
    end
    for (int i = 0; i < 4; i++) begin
      expect_reg(xaui_reg_pkg::REG_TXDATA3 + 5'(i), 16'(tx_stage >> (48 - 16*i)));
    end
    write_reg(xaui_reg_pkg::REG_TXADVANCE, 2'b01, 16'h0001);
    expect_reg(xaui_reg_pkg::REG_TXSTATUS, fifo_status(1, 1'b0));
    compare_value("tx_valid_o", 64'(tx_valid_o), 64'h1);
    compare_value("tx_word_o", tx_word_o, tx_stage);
    @(negedge wb_clk_i);
    tx_pop_i = 1'b1;
    @(negedge wb_clk_i);
    tx_pop_i = 1'b0;
    expect_reg(xaui_reg_pkg::REG_TXSTATUS, fifo_status(0, 1'b0));
    compare_value("tx_valid_o", 64'(tx_valid_o), 64'h0);

    repeat (3) begin
      next_word(w);
      push_rx(w);
    end
    repeat (3) drain_rx_word();
    expect_reg(xaui_reg_pkg::REG_RXSTATUS, fifo_status(0, rx_ovf));
    expect_reg(xaui_reg_pkg::REG_DATACNT0, 16'(data_cnt));

    repeat (6) begin
      next_word(w);
      push_rx(w);
    end
    expect_reg(xaui_reg_pkg::REG_RXSTATUS, fifo_status(rx_model.size(), rx_ovf));
    while (rx_model.size() > 0) drain_rx_word();
    expect_reg(xaui_reg_pkg::REG_RXSTATUS, fifo_status(0, rx_ovf));
    expect_reg(xaui_reg_pkg::REG_DATACNT0, 16'(data_cnt));
    // some errors first so that the clear has something to remove
    repeat (2) pulse_err();
    expect_reg(xaui_reg_pkg::REG_ERRCNT0, 16'(err_cnt));
    write_reg(xaui_reg_pkg::REG_RESET, 2'b01, 16'h0001);
    rx_ovf = 1'b0;
    data_cnt = '0;
    err_cnt = '0;
    expect_reg(xaui_reg_pkg::REG_RXSTATUS, fifo_status(0, rx_ovf));
    expect_reg(xaui_reg_pkg::REG_DATACNT0, 16'(data_cnt));
    expect_reg(xaui_reg_pkg::REG_ERRCNT0, 16'(err_cnt));

    next_word(w);
    write_reg(xaui_reg_pkg::REG_RXPHYCONF, 2'b01, w[15:0]);
    verify_phy(w[1:0], 4'h0, 3'h0, 3'h0);
    write_reg(xaui_reg_pkg::REG_RXPHYCONF, 2'b10, w[31:16]);
    verify_phy(w[1:0], w[27:24], 3'h0, 3'h0);
    write_reg(xaui_reg_pkg::REG_TXPHYCONF, 2'b01, w[47:32]);
    verify_phy(w[1:0], w[27:24], w[34:32], 3'h0);
    write_reg(xaui_reg_pkg::REG_TXPHYCONF, 2'b10, w[63:48]);
    verify_phy(w[1:0], w[27:24], w[34:32], w[58:56]);

    write_reg(xaui_reg_pkg::REG_POWERDOWN, 2'b01, 16'(!P_POWERDOWN));
    compare_value("user_powerdown_o", 64'(user_powerdown_o), 64'(!P_POWERDOWN));
    write_reg(xaui_reg_pkg::REG_LOOPBACK, 2'b01, 16'(!P_LOOPBACK));
    compare_value("user_loopback_o", 64'(user_loopback_o), 64'(!P_LOOPBACK));
    write_reg(xaui_reg_pkg::REG_TXEN, 2'b01, 16'(!P_TXEN));
    compare_value("user_txen_o", 64'(user_txen_o), 64'(!P_TXEN));
    expect_reg(xaui_reg_pkg::REG_POWERDOWN, 16'(!P_POWERDOWN));
    expect_reg(xaui_reg_pkg::REG_LOOPBACK, 16'(!P_LOOPBACK));
    expect_reg(xaui_reg_pkg::REG_TXEN, 16'(!P_TXEN));

    next_word(w);
    @(negedge wb_clk_i);
    xaui_status_i = w[7:0];
    expect_reg(xaui_reg_pkg::REG_LINKSTATUS, {8'h0, w[7:0]});

    repeat (5) pulse_err();
    for (int i = 0; i < 4; i++) begin
      expect_reg(xaui_reg_pkg::REG_ERRCNT3 + 5'(i), 16'(err_cnt >> (48 - 16*i)));
    end

    @(negedge wb_clk_i);
    if (dut.bus_chk.fail_count != 0) begin
      $display("FAIL: see errors above");
      $fatal(1, "checker assertions failed");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
verilog/xaui_reg_pkg.sv
verilog/xaui_fifo_pkg.sv
verilog/xaui_sync_fifo.sv
verilog/xaui_link_counters.sv
verilog/xaui_wb_attach.sv
verilog/xaui_wb_subsys.sv
sim/xaui_wb_checker.sv
sim/xaui_wb_tb.sv

// ==== Makefile ====
TOP := xaui_wb_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
